/* vlog.f */
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_ifu.sv
rtl/rv_idu.sv
rtl/rv_exu.sv
rtl/rv_lsu.sv
rtl/rv_bus_arbiter.sv
rtl/rv_core_top.sv
verif/tb_clkgen.sv
verif/rv_core_tb.sv

/* verif/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int NUM_TESTS = 6;
  localparam int CLK_NS    = 40;
  localparam int RNG_SEED  = 34;
  // 200 instructions at up to 10 cycles each
  localparam int WATCHDOG_NS = 200 * 10 * CLK_NS;
  localparam logic [XLEN-1:0] DATA_BASE = 32'h200;

  typedef struct packed {
    logic [2:0]      tag;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } req_t;

  logic              clk, rst;
  logic              rst_q = 1'b0;
  logic              mem_req_valid_o, mem_req_ready_i, mem_req_write_o;
  logic [XLEN-1:0]   mem_req_addr_o, mem_req_wdata_o;
  logic [STRB_W-1:0] mem_req_wstrb_o;
  logic              mem_rsp_valid_i;
  logic [XLEN-1:0]   mem_rsp_data_i;
  logic              halt_o;

  logic [XLEN-1:0] mem [0:MEM_WORDS-1];
  req_t            exp_q[$];
  req_t            head;
  logic            take, pending, take_write;
  logic [XLEN-1:0] take_addr, take_wdata;
  int              stall;
  int              errors, err_mark, n_pass, n_fail;
  string           test_name [NUM_TESTS];

  tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

  rv_core_top uut (
    .clk(clk), .rst(rst),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
    .mem_req_write_o(mem_req_write_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_wdata_o(mem_req_wdata_o), .mem_req_wstrb_o(mem_req_wstrb_o),
    .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_data_i(mem_rsp_data_i),
    .halt_o(halt_o)
  );

  // RV32I instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic place(input logic [XLEN-1:0] addr, input logic [31:0] word);
    mem[addr[9:2]] = word;
  endtask

  task automatic load_program();
    int stored_regs [9] = '{1, 4, 5, 6, 7, 8, 9, 10, 11};
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hA5C3_0000 ^ (i * 4);
    end
    place(32'h00, u_type(20'h12345, 5'd1));
    place(32'h04, i_type(12'd100, 5'd0, 3'b000, 5'd2, 7'b0010011));
    place(32'h08, i_type(12'hFF9, 5'd0, 3'b000, 5'd3, 7'b0010011));
    place(32'h0C, r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
    place(32'h10, r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));
    place(32'h14, r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd6));
    place(32'h18, r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));
    place(32'h1C, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
    place(32'h20, r_type(7'h00, 5'd2, 5'd3, 3'b010, 5'd9));
    place(32'h24, r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd10));
    place(32'h28, i_type(12'h7FF, 5'd1, 3'b000, 5'd11, 7'b0010011));
    place(32'h2C, i_type(12'h200, 5'd0, 3'b000, 5'd12, 7'b0010011));
    for (int i = 0; i < 9; i++) begin
      place(32'h30 + 4 * i, s_type(12'(4 * i), 5'(stored_regs[i]), 5'd12));
    end
    place(32'h54, i_type(12'd4, 5'd12, 3'b010, 5'd13, 7'b0000011));
    place(32'h58, s_type(12'd36, 5'd13, 5'd12));
    place(32'h5C, i_type(12'd55, 5'd0, 3'b000, 5'd0, 7'b0010011));
    place(32'h60, s_type(12'd40, 5'd0, 5'd12));
    place(32'h64, b_type(13'd8, 5'd3, 5'd2, 3'b000));
    place(32'h68, b_type(13'd8, 5'd3, 5'd2, 3'b001));
    place(32'h70, b_type(13'd8, 5'd2, 5'd2, 3'b000));
    place(32'h78, b_type(13'd8, 5'd2, 5'd2, 3'b001));
    place(32'h7C, j_type(21'd12, 5'd15));
    // Skipped slots keep the fill pattern
    place(32'h88, s_type(12'd48, 5'd15, 5'd12));
    place(32'h8C, 32'h0010_0073);
  endtask

  task automatic access_expected(input int tag, input logic write,
                                 input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    exp_q.push_back('{tag: 3'(tag), write: write, addr: addr, data: data});
  endtask

  task automatic fetch_expected(input int tag, input logic [XLEN-1:0] pc);
    access_expected(tag, 1'b0, pc, '0);
  endtask

  task automatic build_expected();
    logic [XLEN-1:0] x1, x2, x3;
    logic [XLEN-1:0] alu_exp [9];
    int              flow_pc [6] = '{'h64, 'h68, 'h70, 'h78, 'h7C, 'h88};
    x1 = {20'h12345, 12'h000};
    x2 = 32'd100;
    // ADDI immediate 0xFF9 sign extended
    x3 = {{20{1'b1}}, 12'hFF9};
    alu_exp[0] = x1;
    alu_exp[1] = x2 + x3;
    alu_exp[2] = x2 - x3;
    alu_exp[3] = x1 & x3;
    alu_exp[4] = x2 | x3;
    alu_exp[5] = x1 ^ x2;
    alu_exp[6] = ($signed(x3) < $signed(x2)) ? 32'd1 : 32'd0;
    alu_exp[7] = ($signed(x2) < $signed(x3)) ? 32'd1 : 32'd0;
    alu_exp[8] = x1 + 32'd2047;
    fetch_expected(0, PC_INIT);
    for (int pc = 'h04; pc <= 'h2C; pc += 4) begin
      fetch_expected(1, pc);
    end
    for (int i = 0; i < 9; i++) begin
      fetch_expected(1, 32'h30 + 4 * i);
      access_expected(1, 1'b1, DATA_BASE + 4 * i, alu_exp[i]);
    end
    fetch_expected(2, 32'h54);
    access_expected(2, 1'b0, DATA_BASE + 4, '0);
    fetch_expected(2, 32'h58);
    access_expected(2, 1'b1, DATA_BASE + 36, alu_exp[1]);
    fetch_expected(3, 32'h5C);
    fetch_expected(3, 32'h60);
    access_expected(3, 1'b1, DATA_BASE + 40, '0);
    // BEQ falls through, BNE and BEQ jump, BNE falls through, JAL skips two
    for (int i = 0; i < 6; i++) begin
      fetch_expected(4, flow_pc[i]);
    end
    access_expected(4, 1'b1, DATA_BASE + 48, 32'h7C + 32'd4);
    fetch_expected(5, 32'h8C);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input int tag);
    if (errors == err_mark) begin
      n_pass++;
      $display("test %s: ok", test_name[tag]);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", test_name[tag], errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic check_request();
    if (exp_q.size() == 0) begin
      report_error($sformatf("request to %h beyond the expected sequence", take_addr));
    end else begin
      head = exp_q.pop_front();
      assert (take_write == head.write && take_addr == head.addr &&
              (!head.write || take_wdata == head.data))
        else report_error($sformatf("expected %s %h data %h, got %s %h data %h",
                                    head.write ? "write" : "read", head.addr, head.data,
                                    take_write ? "write" : "read", take_addr, take_wdata));
      if (exp_q.size() > 0 && exp_q[0].tag != head.tag) begin
        close_test(head.tag);
      end
    end
  endtask

  // Memory model with random accept delay and one-cycle response
  initial begin
    void'($urandom(RNG_SEED));
    forever begin
      @(posedge clk);
      take       = mem_req_valid_o && mem_req_ready_i;
      pending    = mem_req_valid_o && !mem_req_ready_i;
      take_write = mem_req_write_o;
      take_addr  = mem_req_addr_o;
      take_wdata = mem_req_wdata_o;
      if (take) begin
        check_request();
      end
      #1;
      mem_rsp_valid_i = 1'b0;
      if (take) begin
        if (take_write) begin
          mem[take_addr[9:2]] = take_wdata;
        end
        mem_rsp_data_i  = mem[take_addr[9:2]];
        mem_rsp_valid_i = 1'b1;
        stall           = $urandom_range(3, 0);
      end else if (pending && stall > 0) begin
        stall = stall - 1;
      end
      mem_req_ready_i = (stall == 0);
    end
  end

  // Registers settle at the first reset edge
  always @(posedge clk) begin
    rst_q <= rst;
  end

  a_reset_quiet: assert property (@(posedge clk) rst_q |-> !mem_req_valid_o)
    else report_error("request valid during reset");

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid_o && !mem_req_ready_i) |=>
    (mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_write_o) &&
     $stable(mem_req_wdata_o) && $stable(mem_req_wstrb_o)))
    else report_error("request changed while stalled");

  a_full_strobe: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid_o && mem_req_write_o) |-> (mem_req_wstrb_o == '1))
    else report_error("write strobes not all ones");

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt_o |-> !mem_req_valid_o)
    else report_error("request issued after halt");

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt_o |=> halt_o)
    else report_error("halt_o dropped");

  initial begin
    errors          = 0;
    err_mark        = 0;
    n_pass          = 0;
    n_fail          = 0;
    stall           = 1;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    test_name = '{"reset", "alu", "load_store", "x0", "control_flow", "halt"};
    load_program();
    build_expected();
    wait (halt_o === 1'b1);
    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected memory requests never appeared", exp_q.size());
    end
    close_test(5);
    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the core did not halt within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  wire                            clk,
  input  wire                            rst,
  output logic                           mem_req_valid_o,
  input  wire                            mem_req_ready_i,
  output logic                           mem_req_write_o,
  output logic [rv_core_pkg::XLEN-1:0]   mem_req_addr_o,
  output logic [rv_core_pkg::XLEN-1:0]   mem_req_wdata_o,
  output logic [rv_core_pkg::STRB_W-1:0] mem_req_wstrb_o,
  input  wire                            mem_rsp_valid_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   mem_rsp_data_i,
  output logic                           halt_o
);
  import rv_core_pkg::*;

  logic                  ifu_valid, idu_ready, idu_valid, exu_ready;
  logic [XLEN-1:0]       ifu_inst, ifu_pc, idu_pc, npc;
  logic [REG_ADDR_W-1:0] rs1, rs2, idu_rd, rf_waddr;
  logic [XLEN-1:0]       rdata1, rdata2, op_a, op_b, store_data, imm, rf_wdata;
  alu_op_e               alu_op;
  logic                  rwen, load, store, branch, branch_ne, jal, ebreak;
  logic                  commit, rf_we;
  logic                  lsu_valid, lsu_write, lsu_done;
  logic [XLEN-1:0]       lsu_addr, lsu_wdata, lsu_rdata;
  logic                  fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
  logic [XLEN-1:0]       fetch_req_addr, fetch_rsp_data;
  logic                  data_req_valid, data_req_ready, data_req_write, data_rsp_valid;
  logic [XLEN-1:0]       data_req_addr, data_req_wdata, data_rsp_data;
  logic [STRB_W-1:0]     data_req_wstrb;

  rv_ifu u_ifu (
    .clk(clk), .rst(rst),
    .commit_i(commit), .npc_i(npc), .halt_i(halt_o),
    .valid_o(ifu_valid), .ready_i(idu_ready), .inst_o(ifu_inst), .pc_o(ifu_pc),
    .fetch_req_valid_o(fetch_req_valid), .fetch_req_ready_i(fetch_req_ready),
    .fetch_req_addr_o(fetch_req_addr),
    .fetch_rsp_valid_i(fetch_rsp_valid), .fetch_rsp_data_i(fetch_rsp_data)
  );

  rv_idu u_idu (
    .clk(clk), .rst(rst),
    .valid_i(ifu_valid), .ready_o(idu_ready), .inst_i(ifu_inst), .pc_i(ifu_pc),
    .valid_o(idu_valid), .ready_i(exu_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .rd_o(idu_rd), .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data),
    .imm_o(imm), .pc_o(idu_pc), .alu_op_o(alu_op),
    .rwen_o(rwen), .load_o(load), .store_o(store), .branch_o(branch),
    .branch_ne_o(branch_ne), .jal_o(jal), .ebreak_o(ebreak)
  );

  rv_exu u_exu (
    .clk(clk), .rst(rst),
    .valid_i(idu_valid), .rd_i(idu_rd), .op_a_i(op_a), .op_b_i(op_b),
    .store_data_i(store_data), .imm_i(imm), .pc_i(idu_pc), .alu_op_i(alu_op),
    .rwen_i(rwen), .load_i(load), .store_i(store), .branch_i(branch),
    .branch_ne_i(branch_ne), .jal_i(jal), .ebreak_i(ebreak),
    .ready_o(exu_ready), .commit_o(commit), .npc_o(npc), .halt_o(halt_o),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .lsu_valid_o(lsu_valid), .lsu_write_o(lsu_write), .lsu_addr_o(lsu_addr),
    .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata)
  );

  rv_lsu u_lsu (
    .clk(clk), .rst(rst),
    .valid_i(lsu_valid), .write_i(lsu_write), .addr_i(lsu_addr), .wdata_i(lsu_wdata),
    .done_o(lsu_done), .rdata_o(lsu_rdata),
    .data_req_valid_o(data_req_valid), .data_req_ready_i(data_req_ready),
    .data_req_write_o(data_req_write), .data_req_addr_o(data_req_addr),
    .data_req_wdata_o(data_req_wdata), .data_req_wstrb_o(data_req_wstrb),
    .data_rsp_valid_i(data_rsp_valid), .data_rsp_data_i(data_rsp_data)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rf_waddr), .raddr1_i(rs1), .raddr2_i(rs2),
    .wdata_i(rf_wdata), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  rv_bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .fetch_req_valid_i(fetch_req_valid), .fetch_req_ready_o(fetch_req_ready),
    .fetch_req_addr_i(fetch_req_addr),
    .fetch_rsp_valid_o(fetch_rsp_valid), .fetch_rsp_data_o(fetch_rsp_data),
    .data_req_valid_i(data_req_valid), .data_req_ready_o(data_req_ready),
    .data_req_write_i(data_req_write), .data_req_addr_i(data_req_addr),
    .data_req_wdata_i(data_req_wdata), .data_req_wstrb_i(data_req_wstrb),
    .data_rsp_valid_o(data_rsp_valid), .data_rsp_data_o(data_rsp_data),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
    .mem_req_write_o(mem_req_write_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_wdata_o(mem_req_wdata_o), .mem_req_wstrb_o(mem_req_wstrb_o),
    .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_data_i(mem_rsp_data_i)
  );

endmodule

`default_nettype wire

/* rtl/rv_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_bus_arbiter (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            fetch_req_valid_i,
  output logic                           fetch_req_ready_o,
  input  wire  [rv_core_pkg::XLEN-1:0]   fetch_req_addr_i,
  output logic                           fetch_rsp_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]   fetch_rsp_data_o,
  input  wire                            data_req_valid_i,
  output logic                           data_req_ready_o,
  input  wire                            data_req_write_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   data_req_addr_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   data_req_wdata_i,
  input  wire  [rv_core_pkg::STRB_W-1:0] data_req_wstrb_i,
  output logic                           data_rsp_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]   data_rsp_data_o,
  output logic                           mem_req_valid_o,
  input  wire                            mem_req_ready_i,
  output logic                           mem_req_write_o,
  output logic [rv_core_pkg::XLEN-1:0]   mem_req_addr_o,
  output logic [rv_core_pkg::XLEN-1:0]   mem_req_wdata_o,
  output logic [rv_core_pkg::STRB_W-1:0] mem_req_wstrb_o,
  input  wire                            mem_rsp_valid_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   mem_rsp_data_i
);

  logic busy;
  logic owner_data;
  logic grant_data;
  logic accept;

  // Data side has priority
  assign grant_data = data_req_valid_i;

  assign mem_req_valid_o = !busy && (data_req_valid_i || fetch_req_valid_i);
  assign mem_req_write_o = grant_data && data_req_write_i;
  assign mem_req_addr_o  = grant_data ? data_req_addr_i : fetch_req_addr_i;
  assign mem_req_wdata_o = grant_data ? data_req_wdata_i : '0;
  assign mem_req_wstrb_o = grant_data ? data_req_wstrb_i : '0;

  assign data_req_ready_o  = !busy && mem_req_ready_i;
  assign fetch_req_ready_o = !busy && !data_req_valid_i && mem_req_ready_i;
  assign accept            = mem_req_valid_o && mem_req_ready_i;

  assign fetch_rsp_valid_o = busy && !owner_data && mem_rsp_valid_i;
  assign data_rsp_valid_o  = busy && owner_data && mem_rsp_valid_i;
  assign fetch_rsp_data_o  = mem_rsp_data_i;
  assign data_rsp_data_o   = mem_rsp_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
    end else if (accept) begin
      busy       <= 1'b1;
      owner_data <= grant_data;
    end else if (mem_rsp_valid_i) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_lsu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            valid_i,
  input  wire                            write_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   addr_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   wdata_i,
  output logic                           done_o,
  output logic [rv_core_pkg::XLEN-1:0]   rdata_o,
  output logic                           data_req_valid_o,
  input  wire                            data_req_ready_i,
  output logic                           data_req_write_o,
  output logic [rv_core_pkg::XLEN-1:0]   data_req_addr_o,
  output logic [rv_core_pkg::XLEN-1:0]   data_req_wdata_o,
  output logic [rv_core_pkg::STRB_W-1:0] data_req_wstrb_o,
  input  wire                            data_rsp_valid_i,
  input  wire  [rv_core_pkg::XLEN-1:0]   data_rsp_data_i
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_RSP} state_e;

  state_e state;

  assign data_req_valid_o = (state == S_REQ);
  // Word accesses only
  assign data_req_wstrb_o = '1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= S_IDLE;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE: if (valid_i) state <= S_REQ;
        S_REQ:  if (data_req_ready_i) state <= S_RSP;
        S_RSP: begin
          if (data_rsp_valid_i) begin
            done_o <= 1'b1;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && valid_i) begin
      data_req_write_o <= write_i;
      data_req_addr_o  <= addr_i;
      data_req_wdata_o <= wdata_i;
    end
    if ((state == S_RSP) && data_rsp_valid_i) begin
      rdata_o <= data_rsp_data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_exu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exu (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                valid_i,
  input  wire  [rv_core_pkg::REG_ADDR_W-1:0] rd_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       op_a_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       op_b_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       store_data_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       imm_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       pc_i,
  input  wire  rv_core_pkg::alu_op_e         alu_op_i,
  input  wire                                rwen_i,
  input  wire                                load_i,
  input  wire                                store_i,
  input  wire                                branch_i,
  input  wire                                branch_ne_i,
  input  wire                                jal_i,
  input  wire                                ebreak_i,
  output logic                               ready_o,
  output logic                               commit_o,
  output logic [rv_core_pkg::XLEN-1:0]       npc_o,
  output logic                               halt_o,
  output logic                               rf_we_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                               lsu_valid_o,
  output logic                               lsu_write_o,
  output logic [rv_core_pkg::XLEN-1:0]       lsu_addr_o,
  output logic [rv_core_pkg::XLEN-1:0]       lsu_wdata_o,
  input  wire                                lsu_done_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       lsu_rdata_i
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM} state_e;

  state_e          state;
  logic [XLEN-1:0] alu_res, pc_seq, res_q;
  logic            taken, accept, mem_op;
  logic            rwen_q, load_q, ebreak_q, halt_q;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:   alu_res = op_a_i + op_b_i;
      ALU_SUB:   alu_res = op_a_i - op_b_i;
      ALU_AND:   alu_res = op_a_i & op_b_i;
      ALU_OR:    alu_res = op_a_i | op_b_i;
      ALU_XOR:   alu_res = op_a_i ^ op_b_i;
      ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      ALU_PASSB: alu_res = op_b_i;
      default:   alu_res = '0;
    endcase
  end

  assign pc_seq = pc_i + 32'd4;
  assign taken  = branch_i && ((op_a_i == op_b_i) != branch_ne_i);
  assign accept = valid_i && ready_o;
  assign mem_op = load_q || lsu_write_o;

  assign ready_o     = (state == S_IDLE);
  assign lsu_valid_o = (state == S_EXEC) && mem_op;
  assign lsu_addr_o  = res_q;
  assign commit_o    = ((state == S_EXEC) && !mem_op) || ((state == S_MEM) && lsu_done_i);
  assign rf_we_o     = commit_o && rwen_q;
  assign rf_wdata_o  = load_q ? lsu_rdata_i : res_q;
  assign halt_o      = halt_q || (commit_o && ebreak_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= S_IDLE;
      halt_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE:  if (accept) state <= S_EXEC;
        S_EXEC:  state <= mem_op ? S_MEM : S_IDLE;
        S_MEM:   if (lsu_done_i) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
      if (commit_o && ebreak_q) begin
        halt_q <= 1'b1;
      end
    end
  end

  // Result and next PC resolved at accept
  always_ff @(posedge clk) begin
    if (accept) begin
      res_q       <= jal_i ? pc_seq : alu_res;
      npc_o       <= (taken || jal_i) ? pc_i + imm_i : pc_seq;
      rf_waddr_o  <= rd_i;
      rwen_q      <= rwen_i;
      load_q      <= load_i;
      lsu_write_o <= store_i;
      lsu_wdata_o <= store_data_i;
      ebreak_q    <= ebreak_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_idu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_idu (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                valid_i,
  output logic                               ready_o,
  input  wire  [rv_core_pkg::XLEN-1:0]       inst_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       pc_i,
  output logic                               valid_o,
  input  wire                                ready_i,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_o,
  input  wire  [rv_core_pkg::XLEN-1:0]       rdata1_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       rdata2_i,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       op_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       op_b_o,
  output logic [rv_core_pkg::XLEN-1:0]       store_data_o,
  output logic [rv_core_pkg::XLEN-1:0]       imm_o,
  output logic [rv_core_pkg::XLEN-1:0]       pc_o,
  output rv_core_pkg::alu_op_e               alu_op_o,
  output logic                               rwen_o,
  output logic                               load_o,
  output logic                               store_o,
  output logic                               branch_o,
  output logic                               branch_ne_o,
  output logic                               jal_o,
  output logic                               ebreak_o
);
  import rv_core_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] d_imm, d_op_b;
  alu_op_e         d_alu;
  logic            d_rwen, d_load, d_store, d_branch, d_jal, d_ebreak;
  logic            valid_q;
  logic            accept;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign ready_o = !valid_q;
  assign valid_o = valid_q;
  assign accept  = valid_i && ready_o;

  // Anything unrecognised falls through as a no-op
  always_comb begin
    d_imm    = '0;
    d_op_b   = rdata2_i;
    d_alu    = ALU_ADD;
    d_rwen   = 1'b0;
    d_load   = 1'b0;
    d_store  = 1'b0;
    d_branch = 1'b0;
    d_jal    = 1'b0;
    d_ebreak = 1'b0;
    case (opcode)
      OPC_OP: begin
        d_rwen = 1'b1;
        case (funct3)
          3'b000:  d_alu = inst_i[30] ? ALU_SUB : ALU_ADD;
          3'b010:  d_alu = ALU_SLT;
          3'b100:  d_alu = ALU_XOR;
          3'b110:  d_alu = ALU_OR;
          3'b111:  d_alu = ALU_AND;
          default: d_rwen = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        d_rwen = (funct3 == 3'b000);
        d_imm  = imm_i;
        d_op_b = imm_i;
      end
      OPC_LUI: begin
        d_rwen = 1'b1;
        d_imm  = imm_u;
        d_op_b = imm_u;
        d_alu  = ALU_PASSB;
      end
      OPC_LOAD: begin
        d_rwen = 1'b1;
        d_load = 1'b1;
        d_imm  = imm_i;
        d_op_b = imm_i;
      end
      OPC_STORE: begin
        d_store = 1'b1;
        d_imm   = imm_s;
        d_op_b  = imm_s;
      end
      OPC_BRANCH: begin
        // BEQ and BNE only
        d_branch = (funct3[2:1] == 2'b00);
        d_imm    = imm_b;
      end
      OPC_JAL: begin
        d_rwen = 1'b1;
        d_jal  = 1'b1;
        d_imm  = imm_j;
      end
      OPC_SYSTEM: d_ebreak = (inst_i == INST_EBREAK);
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_o         <= inst_i[11:7];
      op_a_o       <= rdata1_i;
      op_b_o       <= d_op_b;
      store_data_o <= rdata2_i;
      imm_o        <= d_imm;
      pc_o         <= pc_i;
      alu_op_o     <= d_alu;
      rwen_o       <= d_rwen;
      load_o       <= d_load;
      store_o      <= d_store;
      branch_o     <= d_branch;
      branch_ne_o  <= funct3[0];
      jal_o        <= d_jal;
      ebreak_o     <= d_ebreak;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_ifu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_ifu (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          commit_i,
  input  wire  [rv_core_pkg::XLEN-1:0] npc_i,
  input  wire                          halt_i,
  output logic                         valid_o,
  input  wire                          ready_i,
  output logic [rv_core_pkg::XLEN-1:0] inst_o,
  output logic [rv_core_pkg::XLEN-1:0] pc_o,
  output logic                         fetch_req_valid_o,
  input  wire                          fetch_req_ready_i,
  output logic [rv_core_pkg::XLEN-1:0] fetch_req_addr_o,
  input  wire                          fetch_rsp_valid_i,
  input  wire  [rv_core_pkg::XLEN-1:0] fetch_rsp_data_i
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {S_REQ, S_WAIT, S_HOLD} state_e;

  state_e state;
  // armed: a fetch of pc_o is still owed
  logic   armed;
  logic   boot;

  assign fetch_req_valid_o = (state == S_REQ) && armed;
  assign fetch_req_addr_o  = pc_o;
  assign valid_o           = (state == S_HOLD);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_REQ;
      armed <= 1'b0;
      boot  <= 1'b1;
      pc_o  <= PC_INIT;
    end else begin
      boot <= 1'b0;
      if (boot) begin
        armed <= 1'b1;
      end
      case (state)
        S_REQ: begin
          if (fetch_req_valid_o && fetch_req_ready_i) begin
            armed <= 1'b0;
            state <= S_WAIT;
          end
        end
        S_WAIT: if (fetch_rsp_valid_i) state <= S_HOLD;
        S_HOLD: if (ready_i) state <= S_REQ;
        default: state <= S_REQ;
      endcase
      // Next PC arrives with commit; no refetch once halted
      if (commit_i) begin
        pc_o  <= npc_i;
        armed <= !halt_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_WAIT) && fetch_rsp_valid_i) begin
      inst_o <= fetch_rsp_data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                we_i,
  input  wire  [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  wire  [rv_core_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  wire  [rv_core_pkg::REG_ADDR_W-1:0] raddr2_i,
  input  wire  [rv_core_pkg::XLEN-1:0]       wdata_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata2_o
);
  import rv_core_pkg::*;

  // No storage behind x0
  logic [XLEN-1:0] regs [1:31];

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int STRB_W     = XLEN / 8;

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_e;

endpackage

`default_nettype wire
